//--- common/tunnel_defines.svh
`ifndef TUNNEL_DEFINES_SVH
`define TUNNEL_DEFINES_SVH

// payload bits carried by one link word
`define TUNNEL_WIDTH 16

// independent channels multiplexed onto each link direction
`define TUNNEL_NUM_CH 2

// receive fifo depth per channel, also the starting credit count of the sender
`define TUNNEL_REMOTE_CREDITS 8

// log2 of the consumed-word count that makes the receiver send a credit message
`define TUNNEL_LG_DECIMATION 2

// a credit message carries all channel counts in a single word, so
// TUNNEL_NUM_CH * $clog2(TUNNEL_REMOTE_CREDITS + 1) must not exceed TUNNEL_WIDTH.
// with the values above that is 2 * 4 = 8 bits out of 16
// the decimation exponent must stay below the credit count width

`endif

//--- common/tunnel_pkg.sv
`include "tunnel_defines.svh"

package tunnel_pkg;

   // one payload word on the link or in a receive fifo
   typedef logic [`TUNNEL_WIDTH-1:0] data_t;

   // credit count, wide enough to hold the full remote credit value
   typedef logic [$clog2(`TUNNEL_REMOTE_CREDITS+1)-1:0] credit_t;

   // channel index, with one extra code for credit messages
   typedef logic [$clog2(`TUNNEL_NUM_CH+1)-1:0] tag_t;

   // the highest tag value marks a credit message
   localparam tag_t CREDIT_TAG = tag_t'(`TUNNEL_NUM_CH);

   // what a link word carries, as seen by the receiver
   typedef enum logic
   {
      LINK_DATA,
      LINK_CREDIT
   } link_kind_e;

endpackage

//--- filelist.f
+incdir+common
common/tunnel_pkg.sv
src/rr_arbiter.sv
src/channel_fifo.sv
tunnel_out/tunnel_out.sv
tunnel_in/tunnel_in.sv
src/tunnel_top.sv
test/tunnel_tb.sv

//--- run_sim.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --top-module tunnel_tb -f filelist.f -o tunnel_sim
./obj_dir/tunnel_sim > sim.log 2>&1
cat sim.log

if grep -q "TESTS PASSED" sim.log
then
   echo "simulation passed"
else
   echo "simulation failed"
   exit 1
fi

//--- src/channel_fifo.sv
`include "tunnel_defines.svh"

module channel_fifo
   import tunnel_pkg::*;
#(
   parameter int unsigned DEPTH = `TUNNEL_REMOTE_CREDITS
)
(
   input  logic  clk_i,
   input  logic  arst_n_i,
   input  data_t data_i,
   input  logic  v_i,
   output data_t data_o,
   output logic  v_o,
   input  logic  yumi_i
);

   localparam int unsigned AW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
   localparam int unsigned CW = $clog2(DEPTH + 1);

   data_t          mem [DEPTH];
   logic [AW-1:0]  wr_ptr_q;
   logic [AW-1:0]  rd_ptr_q;
   logic [CW-1:0]  count_q;

   // upstream credits keep writes from landing on a full buffer
   always_ff @(posedge clk_i)
   begin
      if (v_i)
      begin
         mem[wr_ptr_q] <= data_i;
      end
   end

   always_ff @(posedge clk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         wr_ptr_q <= '0;
         rd_ptr_q <= '0;
         count_q  <= '0;
      end
      else
      begin
         if (v_i)
            wr_ptr_q <= (wr_ptr_q == AW'(DEPTH - 1)) ? '0 : wr_ptr_q + 1'b1;
         if (yumi_i)
            rd_ptr_q <= (rd_ptr_q == AW'(DEPTH - 1)) ? '0 : rd_ptr_q + 1'b1;
         // simultaneous push and pop leave the count unchanged
         if (v_i && !yumi_i)
            count_q <= count_q + 1'b1;
         else if (!v_i && yumi_i)
            count_q <= count_q - 1'b1;
      end
   end

   assign data_o = mem[rd_ptr_q];
   assign v_o    = (count_q != '0);

endmodule

//--- src/rr_arbiter.sv
module rr_arbiter
   import tunnel_pkg::*;
#(
   parameter int unsigned NUM_REQ = 2
)
(
   input  logic                  clk_i,
   input  logic                  arst_n_i,
   input  data_t [NUM_REQ-1:0]   data_i,
   input  logic  [NUM_REQ-1:0]   v_i,
   output logic  [NUM_REQ-1:0]   yumi_o,
   output data_t                 data_o,
   output tag_t                  tag_o,
   output logic                  v_o,
   input  logic                  yumi_i
);

   localparam int unsigned PTR_W = (NUM_REQ > 1) ? $clog2(NUM_REQ) : 1;

   logic [PTR_W-1:0] ptr_q;
   logic [PTR_W-1:0] win_idx;
   logic             found;

   // first valid request at or after the pointer, wrapping around
   always_comb
   begin
      int unsigned idx;
      found   = 1'b0;
      win_idx = '0;
      for (int unsigned k = 0; k < NUM_REQ; k++)
      begin
         idx = int'(ptr_q) + k;
         if (idx >= NUM_REQ)
         begin
            idx = idx - NUM_REQ;
         end
         if (!found && v_i[idx])
         begin
            found   = 1'b1;
            win_idx = PTR_W'(idx);
         end
      end
   end

   assign data_o = data_i[win_idx];
   assign tag_o  = tag_t'(win_idx);
   assign v_o    = found;

   // strobe only the winner, and only when downstream takes the word
   always_comb
   begin
      yumi_o = '0;
      if (yumi_i && found)
      begin
         yumi_o[win_idx] = 1'b1;
      end
   end

   // move past the winner so it has lowest priority next time
   always_ff @(posedge clk_i or negedge arst_n_i)
   begin
      if (!arst_n_i)
      begin
         ptr_q <= '0;
      end
      else if (yumi_i && found)
      begin
         if (win_idx == PTR_W'(NUM_REQ - 1))
            ptr_q <= '0;
         else
            ptr_q <= win_idx + 1'b1;
      end
   end

endmodule

//--- src/tunnel_top.sv
`include "tunnel_defines.svh"

module tunnel_top
   import tunnel_pkg::*;
(
   input  logic                          clk_i,
   input  logic                          arst_n_i,

   // side a sources and sinks
   input  data_t [`TUNNEL_NUM_CH-1:0]    src_data_a_i,
   input  logic  [`TUNNEL_NUM_CH-1:0]    src_valid_a_i,
   output logic  [`TUNNEL_NUM_CH-1:0]    src_yumi_a_o,
   output data_t [`TUNNEL_NUM_CH-1:0]    snk_data_a_o,
   output logic  [`TUNNEL_NUM_CH-1:0]    snk_valid_a_o,
   input  logic  [`TUNNEL_NUM_CH-1:0]    snk_yumi_a_i,

   // side b sources and sinks
   input  data_t [`TUNNEL_NUM_CH-1:0]    src_data_b_i,
   input  logic  [`TUNNEL_NUM_CH-1:0]    src_valid_b_i,
   output logic  [`TUNNEL_NUM_CH-1:0]    src_yumi_b_o,
   output data_t [`TUNNEL_NUM_CH-1:0]    snk_data_b_o,
   output logic  [`TUNNEL_NUM_CH-1:0]    snk_valid_b_o,
   input  logic  [`TUNNEL_NUM_CH-1:0]    snk_yumi_b_i
);

   // link from a to b
   data_t link_data_ab;
   tag_t  link_tag_ab;
   logic  link_valid_ab;
   logic  link_yumi_ab;

   // link from b to a
   data_t link_data_ba;
   tag_t  link_tag_ba;
   logic  link_valid_ba;
   logic  link_yumi_ba;

   // credit paths inside each endpoint
   credit_t [`TUNNEL_NUM_CH-1:0] cred_local_data_a;
   logic                         cred_local_v_a;
   credit_t [`TUNNEL_NUM_CH-1:0] cred_remote_data_a;
   logic                         cred_remote_yumi_a;
   credit_t [`TUNNEL_NUM_CH-1:0] cred_local_data_b;
   logic                         cred_local_v_b;
   credit_t [`TUNNEL_NUM_CH-1:0] cred_remote_data_b;
   logic                         cred_remote_yumi_b;

   tunnel_out tunnel_out_a (
      .clk_i                       (clk_i),
      .arst_n_i                    (arst_n_i),
      .data_i                      (src_data_a_i),
      .valid_i                     (src_valid_a_i),
      .yumi_o                      (src_yumi_a_o),
      .link_data_o                 (link_data_ab),
      .link_tag_o                  (link_tag_ab),
      .link_valid_o                (link_valid_ab),
      .link_yumi_i                 (link_yumi_ab),
      .credit_local_return_data_i  (cred_local_data_a),
      .credit_local_return_v_i     (cred_local_v_a),
      .credit_remote_return_data_i (cred_remote_data_a),
      .credit_remote_return_yumi_o (cred_remote_yumi_a)
   );

   tunnel_in tunnel_in_a (
      .clk_i                       (clk_i),
      .arst_n_i                    (arst_n_i),
      .link_data_i                 (link_data_ba),
      .link_tag_i                  (link_tag_ba),
      .link_valid_i                (link_valid_ba),
      .link_yumi_o                 (link_yumi_ba),
      .data_o                      (snk_data_a_o),
      .valid_o                     (snk_valid_a_o),
      .yumi_i                      (snk_yumi_a_i),
      .credit_local_return_data_o  (cred_local_data_a),
      .credit_local_return_v_o     (cred_local_v_a),
      .credit_remote_return_data_o (cred_remote_data_a),
      .credit_remote_return_yumi_i (cred_remote_yumi_a)
   );

   tunnel_out tunnel_out_b (
      .clk_i                       (clk_i),
      .arst_n_i                    (arst_n_i),
      .data_i                      (src_data_b_i),
      .valid_i                     (src_valid_b_i),
      .yumi_o                      (src_yumi_b_o),
      .link_data_o                 (link_data_ba),
      .link_tag_o                  (link_tag_ba),
      .link_valid_o                (link_valid_ba),
      .link_yumi_i                 (link_yumi_ba),
      .credit_local_return_data_i  (cred_local_data_b),
      .credit_local_return_v_i     (cred_local_v_b),
      .credit_remote_return_data_i (cred_remote_data_b),
      .credit_remote_return_yumi_o (cred_remote_yumi_b)
   );

   tunnel_in tunnel_in_b (
      .clk_i                       (clk_i),
      .arst_n_i                    (arst_n_i),
      .link_data_i                 (link_data_ab),
      .link_tag_i                  (link_tag_ab),
      .link_valid_i                (link_valid_ab),
      .link_yumi_o                 (link_yumi_ab),
      .data_o                      (snk_data_b_o),
      .valid_o                     (snk_valid_b_o),
      .yumi_i                      (snk_yumi_b_i),
      .credit_local_return_data_o  (cred_local_data_b),
      .credit_local_return_v_o     (cred_local_v_b),
      .credit_remote_return_data_o (cred_remote_data_b),
      .credit_remote_return_yumi_i (cred_remote_yumi_b)
   );

endmodule

//--- test/tunnel_golden.txt
# W lines give test, sending side (0 is a, 1 is b), channel, payload, stall of the receiving sink
# E lines give test, receiving side, channel and expected accepted word count, payload and count in hex
W 1 0 0 0101 0
W 1 0 0 0102 0
W 1 0 0 0103 0
W 1 0 0 0104 0
W 1 0 1 0111 0
W 1 0 1 0112 0
E 1 1 0 4
E 1 1 1 2
E 1 0 0 0
E 1 0 1 0
W 2 0 1 0211 0
W 2 1 0 0221 0
W 2 1 0 0222 0
W 2 1 1 0231 0
E 2 1 0 0
E 2 1 1 1
E 2 0 0 2
E 2 0 1 1
W 3 0 0 0301 1
W 3 0 0 0302 1
W 3 0 0 0303 1
W 3 0 0 0304 1
W 3 0 0 0305 1
W 3 0 0 0306 1
W 3 0 0 0307 1
W 3 0 0 0308 1
W 3 0 0 0309 1
W 3 0 1 0311 0
W 3 0 1 0312 0
E 3 1 0 8
E 3 1 1 2
E 3 0 0 0
E 3 0 1 0
E 4 1 0 1
E 4 1 1 0
E 4 0 0 0
E 4 0 1 0

//--- test/tunnel_tb.sv
`include "tunnel_defines.svh"

module tunnel_tb
   import tunnel_pkg::*;
();

   timeunit 1ns;
   timeprecision 1ps;

   localparam int NUM_CH = `TUNNEL_NUM_CH;

   logic               clk;
   logic               arst_n;
   data_t [NUM_CH-1:0] src_data [2];
   logic  [NUM_CH-1:0] src_valid [2];
   logic  [NUM_CH-1:0] src_yumi [2];
   data_t [NUM_CH-1:0] snk_data [2];
   logic  [NUM_CH-1:0] snk_valid [2];
   logic  [NUM_CH-1:0] snk_yumi [2];

   // sources indexed by sending side, expected words by receiving side
   data_t src_q [2][NUM_CH][$];
   data_t exp_q [2][NUM_CH][$];
   logic  stall [2][NUM_CH];
   // a word sat in the sink at the last falling edge and was not being taken
   logic  seen_free [2][NUM_CH];
   int    accepted [2][NUM_CH];
   int    exp_count [2][NUM_CH];

   byte   rec_kind [$];
   int    rec_test [$];
   int    rec_side [$];
   int    rec_ch [$];
   int    rec_val [$];
   int    rec_flag [$];

   int    seed = 92;
   int    word_total = 0;
   int    test_errors = 0;
   int    tests_run = 0;
   int    tests_failed = 0;
   bit    loaded = 1'b0;

   tunnel_top tunnel_top_inst (
      .clk_i         (clk),
      .arst_n_i      (arst_n),
      .src_data_a_i  (src_data[0]),
      .src_valid_a_i (src_valid[0]),
      .src_yumi_a_o  (src_yumi[0]),
      .snk_data_a_o  (snk_data[0]),
      .snk_valid_a_o (snk_valid[0]),
      .snk_yumi_a_i  (snk_yumi[0]),
      .src_data_b_i  (src_data[1]),
      .src_valid_b_i (src_valid[1]),
      .src_yumi_b_o  (src_yumi[1]),
      .snk_data_b_o  (snk_data[1]),
      .snk_valid_b_o (snk_valid[1]),
      .snk_yumi_b_i  (snk_yumi[1])
   );

   initial
   begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   // bound grows with the amount of traffic in the golden file
   initial
   begin
      wait (loaded);
      repeat (word_total * 40 + 2000) @(posedge clk);
      $display("Error at %0t ns: the run did not finish within %0d cycles",
               $time, word_total * 40 + 2000);
      $display("TESTS FAILED");
      $finish;
   end

   task automatic load_golden();
      int    fd;
      string line;
      int    t, s, c, v, f;
      fd = $fopen("test/tunnel_golden.txt", "r");
      if (fd == 0)
      begin
         $display("Error: the golden file test/tunnel_golden.txt could not be opened");
         $display("TESTS FAILED");
         $finish;
      end
      else
      begin
         while ($fgets(line, fd) > 0)
         begin
            if (line.len() > 2 && (line.getc(0) == "W" || line.getc(0) == "E"))
            begin
               f = 0;
               void'($sscanf(line.substr(1, line.len() - 1), "%d %d %d %h %d", t, s, c, v, f));
               rec_kind.push_back(line.getc(0));
               rec_test.push_back(t);
               rec_side.push_back(s);
               rec_ch.push_back(c);
               rec_val.push_back(v);
               rec_flag.push_back(f);
               if (line.getc(0) == "W")
                  word_total++;
            end
         end
         $fclose(fd);
         loaded = 1'b1;
      end
   endtask

   // golden records are read once at time zero
   initial
   begin
      load_golden();
   end

   task automatic drive_inputs();
      for (int s = 0; s < 2; s++)
      begin
         for (int c = 0; c < NUM_CH; c++)
         begin
            src_valid[s][c] <= (src_q[s][c].size() > 0);
            src_data[s][c]  <= (src_q[s][c].size() > 0) ? src_q[s][c][0] : '0;
            // take a word half the time, and only one that is sure to stay put
            snk_yumi[s][c]  <= seen_free[s][c] && !stall[s][c]
                               && (($random(seed) & 1) == 1);
         end
      end
   endtask

   task automatic sample_outputs();
      data_t want;
      for (int s = 0; s < 2; s++)
      begin
         for (int c = 0; c < NUM_CH; c++)
         begin
            if (src_yumi[s][c])
            begin
               assert (src_valid[s][c]) else
               begin
                  $display("Error at %0t ns: source %0d channel %0d was taken while idle",
                           $time, s, c);
                  test_errors++;
               end
               if (src_q[s][c].size() > 0)
                  void'(src_q[s][c].pop_front());
               accepted[1 - s][c]++;
            end
            if (snk_valid[s][c] && snk_yumi[s][c])
            begin
               assert (exp_q[s][c].size() > 0) else
               begin
                  $display("Error at %0t ns: sink %0d channel %0d gave a word never sent",
                           $time, s, c);
                  test_errors++;
               end
               if (exp_q[s][c].size() > 0)
               begin
                  want = exp_q[s][c].pop_front();
                  assert (snk_data[s][c] == want) else
                  begin
                     $display("Mismatch at %0t ns: sink %0d channel %0d gave %h, expected %h",
                              $time, s, c, snk_data[s][c], want);
                     test_errors++;
                  end
               end
            end
            seen_free[s][c] = snk_valid[s][c] && !snk_yumi[s][c];
         end
      end
   endtask

   task automatic run_cycle();
      @(posedge clk);
      drive_inputs();
      @(negedge clk);
      sample_outputs();
   endtask

   // stalled channels only need their credits used up while the rest must drain
   function automatic bit all_done();
      bit done = 1'b1;
      foreach (stall[r, c])
      begin
         if (stall[r][c])
            done &= (accepted[r][c] >= exp_count[r][c]);
         else
            done &= (src_q[1 - r][c].size() == 0) && (exp_q[r][c].size() == 0);
      end
      return done;
   endfunction

   task automatic report_test(input string name);
      tests_run++;
      if (test_errors != 0)
         tests_failed++;
      $display("test %s %s with %0d errors", name,
               (test_errors == 0) ? "pass" : "fail", test_errors);
      test_errors = 0;
   endtask

   initial
   begin
      int idx;
      int t;
      bit stalled;
      arst_n <= 1'b0;
      for (int s = 0; s < 2; s++)
      begin
         src_data[s]  <= '0;
         src_valid[s] <= '0;
         snk_yumi[s]  <= '0;
      end
      foreach (stall[r, c])
      begin
         stall[r][c]     = 1'b0;
         seen_free[r][c] = 1'b0;
      end
      wait (loaded);
      repeat (10) @(posedge clk);
      arst_n <= 1'b1;

      // nothing moves while no source has data
      repeat (3)
      begin
         @(negedge clk);
         assert (snk_valid[0] == '0 && snk_valid[1] == '0
                 && src_yumi[0] == '0 && src_yumi[1] == '0) else
         begin
            $display("Error at %0t ns: a sink valid or source yumi is high after reset", $time);
            test_errors++;
         end
      end
      report_test("reset");

      idx = 0;
      while (idx < rec_test.size())
      begin
         t       = rec_test[idx];
         stalled = 1'b0;
         foreach (stall[r, c])
         begin
            stall[r][c]     = 1'b0;
            accepted[r][c]  = 0;
            exp_count[r][c] = 0;
         end
         while (idx < rec_test.size() && rec_test[idx] == t)
         begin
            if (rec_kind[idx] == "W")
            begin
               src_q[rec_side[idx]][rec_ch[idx]].push_back(data_t'(rec_val[idx]));
               exp_q[1 - rec_side[idx]][rec_ch[idx]].push_back(data_t'(rec_val[idx]));
               stall[1 - rec_side[idx]][rec_ch[idx]] = rec_flag[idx][0];
               stalled = stalled || rec_flag[idx][0];
            end
            else
            begin
               exp_count[rec_side[idx]][rec_ch[idx]] = rec_val[idx];
            end
            idx++;
         end

         while (!all_done())
            run_cycle();
         // hold the stall a while longer so any extra transfer would show
         if (stalled)
            repeat (30) run_cycle();

         foreach (accepted[r, c])
         begin
            assert (accepted[r][c] == exp_count[r][c]) else
            begin
               $display("Mismatch at %0t ns: side %0d channel %0d accepted %0d words, expected %0d",
                        $time, r, c, accepted[r][c], exp_count[r][c]);
               test_errors++;
            end
            if (stall[r][c])
            begin
               assert (snk_valid[r][c]) else
               begin
                  $display("Error at %0t ns: stalled sink %0d channel %0d lost its words",
                           $time, r, c);
                  test_errors++;
               end
            end
         end
         report_test($sformatf("%0d", t));
      end

      $display("summary %0d tests, %0d passed, %0d failed",
               tests_run, tests_run - tests_failed, tests_failed);
      if (tests_failed == 0)
         $display("TESTS PASSED");
      else
         $display("TESTS FAILED");
      $finish;
   end

endmodule

//--- tunnel_in/tunnel_in.sv
`include "tunnel_defines.svh"

module tunnel_in
   import tunnel_pkg::*;
(
   input  logic                              clk_i,
   input  logic                              arst_n_i,

   // incoming link
   input  data_t                             link_data_i,
   input  tag_t                              link_tag_i,
   input  logic                              link_valid_i,
   output logic                              link_yumi_o,

   // per-channel sinks
   output data_t   [`TUNNEL_NUM_CH-1:0]      data_o,
   output logic    [`TUNNEL_NUM_CH-1:0]      valid_o,
   input  logic    [`TUNNEL_NUM_CH-1:0]      yumi_i,

   // credits received from the far side, handed to our tunnel_out
   output credit_t [`TUNNEL_NUM_CH-1:0]      credit_local_return_data_o,
   output logic                              credit_local_return_v_o,

   // words consumed here since the last credit message
   output credit_t [`TUNNEL_NUM_CH-1:0]      credit_remote_return_data_o,
   input  logic                              credit_remote_return_yumi_i
);

   localparam int unsigned NUM_CH = `TUNNEL_NUM_CH;
   localparam int unsigned CW     = $bits(credit_t);

   link_kind_e           link_kind;
   logic                 data_word_v;
   logic    [NUM_CH-1:0] fifo_wr_v;
   credit_t [NUM_CH-1:0] acc_q;

   // fifo room is guaranteed by credits and credit words need no storage
   assign link_yumi_o = link_valid_i;

   assign link_kind   = (link_tag_i == CREDIT_TAG) ? LINK_CREDIT : LINK_DATA;
   assign data_word_v = link_valid_i && (link_kind == LINK_DATA);

   // a credit word is passed on in the cycle it arrives
   assign credit_local_return_v_o = link_valid_i && (link_kind == LINK_CREDIT);

   for (genvar i = 0; i < NUM_CH; i++)
   begin : g_ch
      // unpack this channel's count from the credit word
      assign credit_local_return_data_o[i] = link_data_i[i*CW +: CW];

      assign fifo_wr_v[i] = data_word_v && (link_tag_i == tag_t'(i));

      channel_fifo #(
         .DEPTH (`TUNNEL_REMOTE_CREDITS)
      ) channel_fifo_inst (
         .clk_i    (clk_i),
         .arst_n_i (arst_n_i),
         .data_i   (link_data_i),
         .v_i      (fifo_wr_v[i]),
         .data_o   (data_o[i]),
         .v_o      (valid_o[i]),
         .yumi_i   (yumi_i[i])
      );

      // consumed-word count, restarted whenever a credit message goes out
      always_ff @(posedge clk_i or negedge arst_n_i)
      begin
         if (!arst_n_i)
         begin
            acc_q[i] <= '0;
         end
         else if (credit_remote_return_yumi_i)
         begin
            // a word taken in the same cycle is not lost
            acc_q[i] <= credit_t'(yumi_i[i]);
         end
         else
         begin
            acc_q[i] <= acc_q[i] + credit_t'(yumi_i[i]);
         end
      end
   end

   assign credit_remote_return_data_o = acc_q;

endmodule

//--- tunnel_out/tunnel_out.sv
`include "tunnel_defines.svh"

module tunnel_out
   import tunnel_pkg::*;
(
   input  logic                              clk_i,
   input  logic                              arst_n_i,

   // per-channel sources
   input  data_t   [`TUNNEL_NUM_CH-1:0]      data_i,
   input  logic    [`TUNNEL_NUM_CH-1:0]      valid_i,
   output logic    [`TUNNEL_NUM_CH-1:0]      yumi_o,

   // outgoing link
   output data_t                             link_data_o,
   output tag_t                              link_tag_o,
   output logic                              link_valid_o,
   input  logic                              link_yumi_i,

   // credits coming home from the far receiver, via our tunnel_in
   input  credit_t [`TUNNEL_NUM_CH-1:0]      credit_local_return_data_i,
   input  logic                              credit_local_return_v_i,

   // counts consumed locally, to be sent to the far sender
   input  credit_t [`TUNNEL_NUM_CH-1:0]      credit_remote_return_data_i,
   output logic                              credit_remote_return_yumi_o
);

   localparam int unsigned NUM_CH = `TUNNEL_NUM_CH;
   localparam int unsigned CW     = $bits(credit_t);

   credit_t [NUM_CH-1:0] credit_q;
   logic    [NUM_CH-1:0] local_avail;
   logic    [NUM_CH-1:0] remote_avail;
   logic                 credit_req;
   data_t                credit_payload;
   data_t   [NUM_CH:0]   arb_data;
   logic    [NUM_CH:0]   arb_v;
   logic    [NUM_CH:0]   arb_yumi;

   for (genvar i = 0; i < NUM_CH; i++)
   begin : g_ch
      // up by returned credits, down by one per word sent
      always_ff @(posedge clk_i or negedge arst_n_i)
      begin
         if (!arst_n_i)
         begin
            credit_q[i] <= credit_t'(`TUNNEL_REMOTE_CREDITS);
         end
         else
         begin
            credit_q[i] <= credit_q[i]
                         + (credit_local_return_v_i ? credit_local_return_data_i[i] : '0)
                         - credit_t'(yumi_o[i]);
         end
      end

      assign local_avail[i]  = |credit_q[i];
      // any count at or above the decimation threshold is worth a message
      assign remote_avail[i] = |credit_remote_return_data_i[i][CW-1:`TUNNEL_LG_DECIMATION];
   end

   assign credit_req     = |remote_avail;
   // all counts packed into the low bits, channel 0 lowest
   assign credit_payload = data_t'(credit_remote_return_data_i);

   // the credit slot sits above the channels so its index equals CREDIT_TAG
   assign arb_data = {credit_payload, data_i};
   assign arb_v    = {credit_req, valid_i & local_avail};

   rr_arbiter #(
      .NUM_REQ (NUM_CH + 1)
   ) rr_arbiter_inst (
      .clk_i    (clk_i),
      .arst_n_i (arst_n_i),
      .data_i   (arb_data),
      .v_i      (arb_v),
      .yumi_o   (arb_yumi),
      .data_o   (link_data_o),
      .tag_o    (link_tag_o),
      .v_o      (link_valid_o),
      .yumi_i   (link_yumi_i)
   );

   assign yumi_o                      = arb_yumi[NUM_CH-1:0];
   assign credit_remote_return_yumi_o = arb_yumi[NUM_CH];

endmodule
